//--- hw/lsu_pkg.sv
// shared sizes and encodings for the load/store path into the data TCM
// referenced by scoped names from the decode, memory and result blocks
// and from the testbench

`default_nettype none

package lsu_pkg;

    //////////////////////////////////////////////////
    // memory geometry
    //////////////////////////////////////////////////

    // data path width in bits
    localparam int unsigned DATA_W = 32;

    // byte lanes per memory word
    localparam int unsigned BYTES_PER_WORD = DATA_W / 8;

    // total memory size in bytes, 4 KiB
    localparam int unsigned MEM_BYTES = 4096;

    // number of words in the array
    localparam int unsigned MEM_WORDS = MEM_BYTES / BYTES_PER_WORD;

    // word address width, log2 of MEM_WORDS
    localparam int unsigned WORD_ADR_W = 10;

    //////////////////////////////////////////////////
    // access size codes
    //////////////////////////////////////////////////

    // request size field is two bits wide
    // code 3 is reserved and treated as a misaligned access

    // 8-bit access
    localparam logic [1:0] SIZE_BYTE = 2'd0;

    // 16-bit access, must sit on an even address
    localparam logic [1:0] SIZE_HALF = 2'd1;

    // 32-bit access, must sit on a 4-byte boundary
    localparam logic [1:0] SIZE_WORD = 2'd2;

endpackage

`default_nettype wire

//--- hw/lsu_request_decode.sv
// request decode for the load/store path
// checks alignment, builds byte-lane enables and the word address,
// and places write data into its lanes, all in the request cycle
// the ld_* outputs carry the load format to the result stage

`timescale 1ns/10ps
`default_nettype none

module lsu_request_decode (
    // request from the master
    input  wire logic                         req_valid,
    input  wire logic                         req_wen,
    input  wire logic [1:0]                   req_size,
    input  wire logic                         req_uns,
    input  wire logic [31:0]                  req_adr,
    input  wire logic [lsu_pkg::DATA_W-1:0]   req_wdt,
    // memory access, same cycle
    output logic                              mem_en,
    output logic                              mem_wen,
    output logic [lsu_pkg::WORD_ADR_W-1:0]    mem_adr,
    output logic [lsu_pkg::BYTES_PER_WORD-1:0] mem_byt,
    output logic [lsu_pkg::DATA_W-1:0]        mem_wdt,
    // load format for the result stage
    output logic                              ld_valid,
    output logic                              ld_err,
    output logic                              ld_wen,
    output logic [1:0]                        ld_size,
    output logic                              ld_uns,
    output logic [1:0]                        ld_ofs
);

    // byte address inside the memory, upper bits wrap
    localparam int unsigned BYTE_ADR_W = $clog2(lsu_pkg::MEM_BYTES);

    logic [BYTE_ADR_W-1:0] adr_lo;
    logic [1:0]            ofs;
    logic                  misaligned;

    assign adr_lo = req_adr[BYTE_ADR_W-1:0];
    assign ofs    = adr_lo[1:0];

    //////////////////////////////////////////////////
    // alignment, lanes and write data
    //////////////////////////////////////////////////

    always_comb begin
        misaligned = 1'b0;
        mem_byt    = '0;
        mem_wdt    = req_wdt;
        case (req_size)
            lsu_pkg::SIZE_BYTE: begin
                // any offset is fine, one lane
                mem_byt = 4'b0001 << ofs;
                mem_wdt = {4{req_wdt[7:0]}};
            end
            lsu_pkg::SIZE_HALF: begin
                // odd address is misaligned
                misaligned = ofs[0];
                mem_byt    = 4'b0011 << ofs;
                mem_wdt    = {2{req_wdt[15:0]}};
            end
            lsu_pkg::SIZE_WORD: begin
                misaligned = (ofs != 2'd0);
                mem_byt    = 4'b1111;
            end
            default: begin
                // reserved size code
                misaligned = 1'b1;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // memory side
    //////////////////////////////////////////////////

    // misaligned requests never reach the array
    assign mem_en  = req_valid & ~misaligned;
    assign mem_wen = req_wen;
    // drop the byte offset
    assign mem_adr = adr_lo[BYTE_ADR_W-1:2];

    //////////////////////////////////////////////////
    // result side
    //////////////////////////////////////////////////

    assign ld_valid = req_valid;
    // error only meaningful with a request
    assign ld_err   = req_valid & misaligned;
    assign ld_wen   = req_wen;
    assign ld_size  = req_size;
    assign ld_uns   = req_uns;
    assign ld_ofs   = ofs;

endmodule

`default_nettype wire

//--- hw/tcm_memory.sv
// single-port data TCM, one word wide, byte-enable writes
// a read returns the addressed word one cycle after mem_en
// a write lands at the edge of its request cycle
// written as a plain array so synthesis infers block RAM

`timescale 1ns/10ps
`default_nettype none

module tcm_memory (
    input  wire logic                              sub,
    // access from the decode stage
    input  wire logic                              mem_en,
    input  wire logic                              mem_wen,
    input  wire logic [lsu_pkg::WORD_ADR_W-1:0]    mem_adr,
    input  wire logic [lsu_pkg::BYTES_PER_WORD-1:0] mem_byt,
    input  wire logic [lsu_pkg::DATA_W-1:0]        mem_wdt,
    // registered read data
    output logic [lsu_pkg::DATA_W-1:0]             mem_rdt
);

    //////////////////////////////////////////////////
    // array
    //////////////////////////////////////////////////

    // contents start undefined
    logic [lsu_pkg::DATA_W-1:0] mem [0:lsu_pkg::MEM_WORDS-1];

    //////////////////////////////////////////////////
    // read / write port
    //////////////////////////////////////////////////

    always_ff @(posedge sub) begin
        if (mem_en) begin
            if (mem_wen) begin
                // only the enabled lanes change
                for (int i = 0; i < lsu_pkg::BYTES_PER_WORD; i++) begin
                    if (mem_byt[i]) begin
                        mem[mem_adr][8*i +: 8] <= mem_wdt[8*i +: 8];
                    end
                end
            end else begin
                // read, output holds until next read
                mem_rdt <= mem[mem_adr];
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/lsu_load_result.sv
// response stage of the load/store path
// registers the load format at the same edge as the memory read,
// then picks the addressed byte or half out of mem_rdt and extends it
// stores, errors and idle cycles give zero data

`timescale 1ns/10ps
`default_nettype none

module lsu_load_result (
    input  wire logic                        sub,
    input  wire logic                        reset,
    // load format from the decode stage
    input  wire logic                        ld_valid,
    input  wire logic                        ld_err,
    input  wire logic                        ld_wen,
    input  wire logic [1:0]                  ld_size,
    input  wire logic                        ld_uns,
    input  wire logic [1:0]                  ld_ofs,
    // registered word from the memory
    input  wire logic [lsu_pkg::DATA_W-1:0]  mem_rdt,
    // response
    output logic                             rsp_valid,
    output logic [lsu_pkg::DATA_W-1:0]       rsp_rdt,
    output logic                             rsp_err
);

    //////////////////////////////////////////////////
    // format registers
    //////////////////////////////////////////////////

    logic       valid_q;
    logic       err_q;
    logic       wen_q;
    logic [1:0] size_q;
    logic       uns_q;
    logic [1:0] ofs_q;

    // control state
    always_ff @(posedge sub) begin
        if (reset) begin
            valid_q <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            valid_q <= ld_valid;
            err_q   <= ld_err;
        end
    end

    // format fields, only read while valid_q is high
    always_ff @(posedge sub) begin
        wen_q  <= ld_wen;
        size_q <= ld_size;
        uns_q  <= ld_uns;
        ofs_q  <= ld_ofs;
    end

    //////////////////////////////////////////////////
    // extraction and extension
    //////////////////////////////////////////////////

    logic [7:0]                  ld_byte;
    logic [15:0]                 ld_half;
    logic [lsu_pkg::DATA_W-1:0]  ld_data;

    // byte lane from the offset, half from offset bit 1
    assign ld_byte = mem_rdt[{ofs_q, 3'b000} +: 8];
    assign ld_half = mem_rdt[{ofs_q[1], 4'b0000} +: 16];

    always_comb begin
        case (size_q)
            lsu_pkg::SIZE_BYTE: begin
                // sign bit unless unsigned
                ld_data = {{(lsu_pkg::DATA_W-8){~uns_q & ld_byte[7]}}, ld_byte};
            end
            lsu_pkg::SIZE_HALF: begin
                ld_data = {{(lsu_pkg::DATA_W-16){~uns_q & ld_half[15]}}, ld_half};
            end
            lsu_pkg::SIZE_WORD: begin
                ld_data = mem_rdt;
            end
            default: begin
                // reserved code, already flagged as error
                ld_data = '0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // response
    //////////////////////////////////////////////////

    assign rsp_valid = valid_q;
    assign rsp_err   = err_q;
    // data only for a good load
    assign rsp_rdt   = (valid_q & ~wen_q & ~err_q) ? ld_data : '0;

endmodule

`default_nettype wire

//--- hw/lsu_tcm_top.sv
// top level of the load/store path into the data TCM
// one request per cycle on plain strobes, one response a cycle later
// decode -> memory and result, no back-pressure

`timescale 1ns/10ps
`default_nettype none

module lsu_tcm_top (
    input  wire logic                        sub,
    input  wire logic                        reset,
    // request
    input  wire logic                        req_valid,
    input  wire logic                        req_wen,
    input  wire logic [1:0]                  req_size,
    input  wire logic                        req_uns,
    input  wire logic [31:0]                 req_adr,
    input  wire logic [lsu_pkg::DATA_W-1:0]  req_wdt,
    // response
    output logic                             rsp_valid,
    output logic [lsu_pkg::DATA_W-1:0]       rsp_rdt,
    output logic                             rsp_err
);

    //////////////////////////////////////////////////
    // internal wires
    //////////////////////////////////////////////////

    // decode to memory
    logic                               mem_en;
    logic                               mem_wen;
    logic [lsu_pkg::WORD_ADR_W-1:0]     mem_adr;
    logic [lsu_pkg::BYTES_PER_WORD-1:0] mem_byt;
    logic [lsu_pkg::DATA_W-1:0]         mem_wdt;
    // memory to result
    logic [lsu_pkg::DATA_W-1:0]         mem_rdt;
    // decode to result
    logic                               ld_valid;
    logic                               ld_err;
    logic                               ld_wen;
    logic [1:0]                         ld_size;
    logic                               ld_uns;
    logic [1:0]                         ld_ofs;

    //////////////////////////////////////////////////
    // stages
    //////////////////////////////////////////////////

    lsu_request_decode lsu_request_decode_inst (
        .req_valid (req_valid),
        .req_wen   (req_wen),
        .req_size  (req_size),
        .req_uns   (req_uns),
        .req_adr   (req_adr),
        .req_wdt   (req_wdt),
        .mem_en    (mem_en),
        .mem_wen   (mem_wen),
        .mem_adr   (mem_adr),
        .mem_byt   (mem_byt),
        .mem_wdt   (mem_wdt),
        .ld_valid  (ld_valid),
        .ld_err    (ld_err),
        .ld_wen    (ld_wen),
        .ld_size   (ld_size),
        .ld_uns    (ld_uns),
        .ld_ofs    (ld_ofs)
    );

    tcm_memory tcm_memory_inst (
        .sub     (sub),
        .mem_en  (mem_en),
        .mem_wen (mem_wen),
        .mem_adr (mem_adr),
        .mem_byt (mem_byt),
        .mem_wdt (mem_wdt),
        .mem_rdt (mem_rdt)
    );

    lsu_load_result lsu_load_result_inst (
        .sub       (sub),
        .reset     (reset),
        .ld_valid  (ld_valid),
        .ld_err    (ld_err),
        .ld_wen    (ld_wen),
        .ld_size   (ld_size),
        .ld_uns    (ld_uns),
        .ld_ofs    (ld_ofs),
        .mem_rdt   (mem_rdt),
        .rsp_valid (rsp_valid),
        .rsp_rdt   (rsp_rdt),
        .rsp_err   (rsp_err)
    );

endmodule

`default_nettype wire

//--- verification/lsu_tcm_checker.sv
// bound assertions on the response timing of the load/store path
// attached to every lsu_tcm_top through the bind at the end of the file
// failures raise $error and bump assert_fails for the testbench summary

`timescale 1ns/10ps
`default_nettype none

module lsu_tcm_checker (
    input  wire logic                        sub,
    input  wire logic                        reset,
    input  wire logic                        req_valid,
    input  wire logic                        rsp_valid,
    input  wire logic [lsu_pkg::DATA_W-1:0]  rsp_rdt,
    input  wire logic                        rsp_err
);

    // read by the testbench summary
    int unsigned assert_fails = 0;

    //////////////////////////////////////////////////
    // response timing
    //////////////////////////////////////////////////

    // every request answered exactly one cycle later
    rsp_follows_req: assert property (
        @(posedge sub) disable iff (reset) req_valid |=> rsp_valid
    ) else begin
        assert_fails++;
        $error("no response one cycle after a request");
    end

    // nothing comes out unless something went in
    no_rsp_without_req: assert property (
        @(posedge sub) disable iff (reset) rsp_valid |-> $past(req_valid)
    ) else begin
        assert_fails++;
        $error("response seen without a request in the cycle before");
    end

    // synchronous clear of the valid and error registers
    rsp_low_in_reset: assert property (
        @(posedge sub) reset |=> (!rsp_valid && !rsp_err)
    ) else begin
        assert_fails++;
        $error("rsp_valid or rsp_err high after a reset cycle");
    end

    //////////////////////////////////////////////////
    // error rules
    //////////////////////////////////////////////////

    // misaligned accesses return no data
    err_means_zero_data: assert property (
        @(posedge sub) disable iff (reset) rsp_err |-> (rsp_rdt == '0)
    ) else begin
        assert_fails++;
        $error("rsp_err high with nonzero rsp_rdt");
    end

endmodule

bind lsu_tcm_top lsu_tcm_checker lsu_tcm_checker_inst (
    .sub       (sub),
    .reset     (reset),
    .req_valid (req_valid),
    .rsp_valid (rsp_valid),
    .rsp_rdt   (rsp_rdt),
    .rsp_err   (rsp_err)
);

`default_nettype wire

//--- verification/lsu_tcm_monitor.sv
// response monitor for the load/store path testbench
// loads the same vector file as the driver and pairs the i-th response
// with the i-th vector, printing one line per test as it completes

`timescale 1ns/10ps
`default_nettype none

module lsu_tcm_monitor (
    input  wire logic                        sub,
    input  wire logic                        reset,
    input  wire logic                        rsp_valid,
    input  wire logic [lsu_pkg::DATA_W-1:0]  rsp_rdt,
    input  wire logic                        rsp_err,
    output int unsigned                      rsp_count,
    output int unsigned                      pass_count,
    output int unsigned                      fail_count
);

    // seven hex words per vector line
    localparam int unsigned VEC_MAX = 64;
    localparam int unsigned FIELDS  = 7;

    logic [31:0] vec_mem [0:VEC_MAX*FIELDS-1];
    int unsigned vec_count;

    initial begin
        rsp_count  = 0;
        pass_count = 0;
        fail_count = 0;
        vec_count  = 0;
        $readmemh("verification/lsu_testdata.hex", vec_mem);
        // unfilled entries stay x
        while (vec_count < VEC_MAX && !$isunknown(vec_mem[vec_count*FIELDS])) begin
            vec_count++;
        end
    end

    function automatic string size_name(input logic [1:0] size);
        case (size)
            lsu_pkg::SIZE_BYTE: return "byte";
            lsu_pkg::SIZE_HALF: return "half";
            lsu_pkg::SIZE_WORD: return "word";
            default:            return "rsvd";
        endcase
    endfunction

    //////////////////////////////////////////////////
    // compare, half a cycle after the response edge
    //////////////////////////////////////////////////

    always @(negedge sub) begin : compare
        int unsigned base;
        logic [31:0] exp_rdt;
        logic        exp_err;
        logic        ok;
        string       op;
        if (!reset && rsp_valid === 1'b1) begin
            if (rsp_count >= vec_count) begin
                $display("test %0d: unexpected response with no vector left to match",
                         rsp_count);
                fail_count++;
            end else begin
                base    = rsp_count * FIELDS;
                exp_rdt = vec_mem[base+5];
                exp_err = vec_mem[base+6][0];
                op      = vec_mem[base][0] ? "store" : "load";
                ok      = 1'b1;
                if (rsp_rdt !== exp_rdt) begin
                    $display("error: test %0d rsp_rdt = %08h, expected %08h",
                             rsp_count, rsp_rdt, exp_rdt);
                    ok = 1'b0;
                end
                if (rsp_err !== exp_err) begin
                    $display("error: test %0d rsp_err = %0h, expected %0h",
                             rsp_count, rsp_err, exp_err);
                    ok = 1'b0;
                end
                if (ok) begin
                    pass_count++;
                end else begin
                    fail_count++;
                end
                $display("test %0d: %s %s adr %08h %s", rsp_count, op,
                         size_name(vec_mem[base+1][1:0]), vec_mem[base+3],
                         ok ? "ok" : "failed");
            end
            rsp_count++;
        end
    end

endmodule

`default_nettype wire

//--- verification/lsu_tcm_tb.sv
// testbench for the load/store path into the data TCM
// drives vectors from verification/lsu_testdata.hex back to back,
// the monitor compares responses, the bound checker watches timing

`timescale 1ns/10ps
`default_nettype none

module lsu_tcm_tb;

    localparam int unsigned VEC_MAX = 64;
    localparam int unsigned FIELDS  = 7;

    logic                        sub;
    logic                        reset;
    logic                        req_valid;
    logic                        req_wen;
    logic [1:0]                  req_size;
    logic                        req_uns;
    logic [31:0]                 req_adr;
    logic [lsu_pkg::DATA_W-1:0]  req_wdt;
    logic                        rsp_valid;
    logic [lsu_pkg::DATA_W-1:0]  rsp_rdt;
    logic                        rsp_err;

    logic [31:0] vec_mem [0:VEC_MAX*FIELDS-1];
    int unsigned vec_count;
    int unsigned rsp_count;
    int unsigned pass_count;
    int unsigned fail_count;

    // 100 ns period
    always #50 sub = ~sub;

    lsu_tcm_top lsu_tcm_top_inst (
        .sub       (sub),
        .reset     (reset),
        .req_valid (req_valid),
        .req_wen   (req_wen),
        .req_size  (req_size),
        .req_uns   (req_uns),
        .req_adr   (req_adr),
        .req_wdt   (req_wdt),
        .rsp_valid (rsp_valid),
        .rsp_rdt   (rsp_rdt),
        .rsp_err   (rsp_err)
    );

    lsu_tcm_monitor lsu_tcm_monitor_inst (
        .sub        (sub),
        .reset      (reset),
        .rsp_valid  (rsp_valid),
        .rsp_rdt    (rsp_rdt),
        .rsp_err    (rsp_err),
        .rsp_count  (rsp_count),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic drive_vector(input int unsigned idx);
        int unsigned base;
        base      = idx * FIELDS;
        req_valid = 1'b1;
        req_wen   = vec_mem[base][0];
        req_size  = vec_mem[base+1][1:0];
        req_uns   = vec_mem[base+2][0];
        req_adr   = vec_mem[base+3];
        req_wdt   = vec_mem[base+4];
    endtask

    function automatic int unsigned assertion_failures();
        return lsu_tcm_top_inst.lsu_tcm_checker_inst.assert_fails;
    endfunction

    task automatic report_counts();
        $display("summary: %0d of %0d tests passed, %0d failed, %0d assertion failures",
                 pass_count, vec_count, fail_count, assertion_failures());
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin : stimulus
        int unsigned total_fail;
        sub       = 1'b0;
        reset     = 1'b1;
        // misaligned word load held through reset, must stay unanswered
        req_valid = 1'b1;
        req_wen   = 1'b0;
        req_size  = lsu_pkg::SIZE_WORD;
        req_uns   = 1'b0;
        req_adr   = 32'h0000_0102;
        req_wdt   = '0;
        vec_count = 0;
        $readmemh("verification/lsu_testdata.hex", vec_mem);
        while (vec_count < VEC_MAX && !$isunknown(vec_mem[vec_count*FIELDS])) begin
            vec_count++;
        end
        if (vec_count == 0) begin
            $display("no test vectors could be read from the data file");
        end
        // ten cycles of reset, released on a falling edge
        repeat (10) @(posedge sub);
        @(negedge sub);
        reset     = 1'b0;
        req_valid = 1'b0;
        // back to back, one request per cycle
        for (int i = 0; i < vec_count; i++) begin
            @(negedge sub);
            drive_vector(i);
        end
        @(negedge sub);
        req_valid = 1'b0;
        while (rsp_count < vec_count) begin
            @(negedge sub);
        end
        // room for any stray response
        repeat (2) @(negedge sub);
        total_fail = fail_count + assertion_failures();
        report_counts();
        if (total_fail == 0 && vec_count != 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // cycle limit from the vector count
    initial begin : watchdog
        int unsigned cycles;
        int unsigned limit;
        cycles = 0;
        wait (reset === 1'b0);
        limit = vec_count + 20;
        while (cycles < limit) begin
            @(posedge sub);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d of %0d responses were missing",
                 cycles, vec_count - rsp_count, vec_count);
        report_counts();
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/lsu_testdata.hex
// columns: wen size(0 byte,1 half,2 word) uns address wdata expected_rdata expected_err
// vectors run back to back, one request per cycle
1 2 0 00000100 deadbeef 00000000 0  // word store
0 2 0 00000100 00000000 deadbeef 0  // load right after the store
1 2 0 00000104 12345678 00000000 0
0 2 0 00000104 00000000 12345678 0
1 2 0 00000200 11223344 00000000 0  // base word for byte lanes
1 0 0 00000200 000000a1 00000000 0  // lane 0
0 2 0 00000200 00000000 112233a1 0
1 0 0 00000201 ffffffb2 00000000 0  // lane 1, upper bits ignored
1 0 0 00000202 000000c3 00000000 0  // lane 2
1 0 0 00000203 000000d4 00000000 0  // lane 3
0 2 0 00000200 00000000 d4c3b2a1 0  // merged word
0 0 0 00000200 00000000 ffffffa1 0  // signed byte loads
0 0 1 00000201 00000000 000000b2 0
0 0 0 00000202 00000000 ffffffc3 0
0 0 1 00000203 00000000 000000d4 0
0 1 0 00000200 00000000 ffffb2a1 0  // signed half
0 1 1 00000202 00000000 0000d4c3 0  // unsigned half
1 2 0 00000300 7f80017e 00000000 0
0 0 0 00000300 00000000 0000007e 0  // positive byte
0 0 0 00000303 00000000 0000007f 0
0 0 0 00000302 00000000 ffffff80 0
0 1 0 00000300 00000000 0000017e 0  // positive half
0 1 0 00000302 00000000 00007f80 0
1 1 0 00000302 1234beef 00000000 0  // half store, upper half
0 2 0 00000300 00000000 beef017e 0
0 1 0 00000302 00000000 ffffbeef 0
1 2 0 00000102 55555555 00000000 1  // misaligned word store
1 1 0 00000101 0000aaaa 00000000 1  // misaligned half store
0 2 0 00000101 00000000 00000000 1
0 1 1 00000103 00000000 00000000 1
0 2 0 00000100 00000000 deadbeef 0  // memory unchanged
1 2 0 00001400 cafef00d 00000000 0  // address wraps to 0x400
0 2 0 00000400 00000000 cafef00d 0
0 0 1 fffff401 00000000 000000f0 0
1 0 0 80000403 00000011 00000000 0
0 2 0 00000400 00000000 11fef00d 0
0 1 0 00001402 00000000 000011fe 0

//--- project.f
hw/lsu_pkg.sv
hw/lsu_request_decode.sv
hw/tcm_memory.sv
hw/lsu_load_result.sv
hw/lsu_tcm_top.sv
verification/lsu_tcm_checker.sv
verification/lsu_tcm_monitor.sv
verification/lsu_tcm_tb.sv
